// ==== src/uart_pkg.sv ====
package uart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // byte and bit index
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int unsigned BYTE_BITS = 8;

    typedef logic [BYTE_BITS-1:0] byte_t;

    // selects one data bit inside a frame
    typedef logic [$clog2(BYTE_BITS)-1:0] bit_idx_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // received byte
    // ~~~~~~~~~~~~~~~~~~~~

    // frame_err set when the stop bit sampled low
    typedef struct packed {
        byte_t data;
        logic  frame_err;
    } rx_byte_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // state machines
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

endpackage

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
    parameter int unsigned CLK_PER_BIT = 217
)(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rx_line,
    output uart_pkg::rx_byte_t rx_byte,
    output logic               rx_push
);

    localparam int unsigned CNT_W = $clog2(CLK_PER_BIT);

    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t CNT_LAST = cnt_t'(CLK_PER_BIT - 1);
    localparam cnt_t CNT_HALF = cnt_t'(CLK_PER_BIT / 2 - 1);
    localparam uart_pkg::bit_idx_t LAST_BIT = uart_pkg::bit_idx_t'(uart_pkg::BYTE_BITS - 1);

    logic                rx_meta;
    logic                rx_sync;
    logic                rx_prev;
    uart_pkg::rx_state_t state;
    cnt_t                cnt;
    uart_pkg::bit_idx_t  bit_idx;
    uart_pkg::byte_t     shift;

    // ~~~~~~~~~~~~~~~~~~~~
    // input synchronizer
    // ~~~~~~~~~~~~~~~~~~~~

    // line idles high, so reset to 1
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // deframing FSM
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= uart_pkg::rx_idle;
            cnt     <= '0;
            bit_idx <= '0;
            rx_push <= 1'b0;
        end
        else
        begin
            rx_push <= 1'b0;
            case (state)
                uart_pkg::rx_idle:
                begin
                    cnt <= '0;
                    // falling edge marks the start bit
                    if (rx_prev && !rx_sync)
                        state <= uart_pkg::rx_start;
                end
                uart_pkg::rx_start:
                begin
                    if (cnt == CNT_HALF)
                    begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // glitch, line already back high
                        if (rx_sync)
                            state <= uart_pkg::rx_idle;
                        else
                            state <= uart_pkg::rx_data;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                uart_pkg::rx_data:
                begin
                    if (cnt == CNT_LAST)
                    begin
                        cnt <= '0;
                        if (bit_idx == LAST_BIT)
                            state <= uart_pkg::rx_stop;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                uart_pkg::rx_stop:
                begin
                    if (cnt == CNT_LAST)
                    begin
                        cnt     <= '0;
                        rx_push <= 1'b1;
                        state   <= uart_pkg::rx_idle;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                default:
                    state <= uart_pkg::rx_idle;
            endcase
        end
    end

    // data path, LSB arrives first
    always_ff @(posedge clk)
    begin
        if (state == uart_pkg::rx_data && cnt == CNT_LAST)
            shift <= {rx_sync, shift[uart_pkg::BYTE_BITS-1:1]};
        if (state == uart_pkg::rx_stop && cnt == CNT_LAST)
        begin
            rx_byte.data      <= shift;
            rx_byte.frame_err <= !rx_sync;
        end
    end

endmodule

// ==== src/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo #(
    parameter int unsigned FIFO_DEPTH = 8
)(
    input  logic               clk,
    input  logic               rst_n,
    input  uart_pkg::rx_byte_t wr_entry,
    input  logic               wr_strobe,
    output uart_pkg::rx_byte_t rd_entry,
    output logic               rd_valid,
    input  logic               rd_ready,
    output logic               overrun
);

    localparam int unsigned AW = $clog2(FIFO_DEPTH);

    // extra msb tells full from empty
    typedef logic [AW:0] ptr_t;

    uart_pkg::rx_byte_t mem [FIFO_DEPTH];
    ptr_t               wr_ptr;
    ptr_t               rd_ptr;
    logic               full;
    logic               empty;
    logic               do_push;
    logic               do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push = wr_strobe && !full;
    assign do_pop  = rd_valid && rd_ready;

    assign rd_valid = !empty;
    assign rd_entry = mem[rd_ptr[AW-1:0]];

    // ~~~~~~~~~~~~~~~~~~~~
    // pointers and flags
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            overrun <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // sticky until reset
            if (wr_strobe && full)
                overrun <= 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr[AW-1:0]] <= wr_entry;
    end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
    parameter int unsigned CLK_PER_BIT = 217
)(
    input  logic               clk,
    input  logic               rst_n,
    input  uart_pkg::rx_byte_t tx_entry,
    input  logic               tx_valid,
    output logic               tx_ready,
    input  logic               hold,
    output logic               tx_line
);

    localparam int unsigned CNT_W = $clog2(CLK_PER_BIT);

    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t CNT_LAST = cnt_t'(CLK_PER_BIT - 1);
    localparam uart_pkg::bit_idx_t LAST_BIT = uart_pkg::bit_idx_t'(uart_pkg::BYTE_BITS - 1);

    uart_pkg::tx_state_t       state;
    cnt_t                      cnt;
    uart_pkg::bit_idx_t        bit_idx;
    logic [uart_pkg::BYTE_BITS:0] shift;
    logic                      take;
    logic                      bit_end;

    // new bytes only between frames
    assign tx_ready = (state == uart_pkg::tx_idle) && !hold;
    assign take     = tx_valid && tx_ready;
    assign bit_end  = (cnt == CNT_LAST);

    // ~~~~~~~~~~~~~~~~~~~~
    // framing FSM
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= uart_pkg::tx_idle;
            cnt     <= '0;
            bit_idx <= '0;
            tx_line <= 1'b1;
        end
        else
        begin
            if (state != uart_pkg::tx_idle)
                cnt <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                uart_pkg::tx_idle:
                begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    // flagged entries are popped and dropped here
                    if (take && !tx_entry.frame_err)
                    begin
                        tx_line <= 1'b0;
                        state   <= uart_pkg::tx_start;
                    end
                end
                uart_pkg::tx_start:
                begin
                    if (bit_end)
                    begin
                        tx_line <= shift[0];
                        state   <= uart_pkg::tx_data;
                    end
                end
                uart_pkg::tx_data:
                begin
                    if (bit_end)
                    begin
                        // after the last data bit shift[0] holds the stop bit
                        tx_line <= shift[0];
                        if (bit_idx == LAST_BIT)
                            state <= uart_pkg::tx_stop;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                end
                uart_pkg::tx_stop:
                begin
                    if (bit_end)
                        state <= uart_pkg::tx_idle;
                end
                default:
                    state <= uart_pkg::tx_idle;
            endcase
        end
    end

    // stop bit rides above the data byte
    always_ff @(posedge clk)
    begin
        if (take)
            shift <= {1'b1, tx_entry.data};
        else if (bit_end && (state == uart_pkg::tx_start || state == uart_pkg::tx_data))
            shift <= {1'b1, shift[uart_pkg::BYTE_BITS:1]};
    end

endmodule

// ==== src/uart_bridge_top.sv ====
`timescale 1ns/1ps

module uart_bridge_top #(
    parameter int unsigned CLK_PER_BIT = 217,
    parameter int unsigned FIFO_DEPTH  = 8
)(
    input  logic clk,
    input  logic rst_n,
    input  logic rx_line,
    input  logic tx_hold,
    output logic tx_line,
    output logic overrun
);

    uart_pkg::rx_byte_t rx_byte;
    logic               rx_push;
    uart_pkg::rx_byte_t fifo_out;
    logic               fifo_valid;
    logic               fifo_ready;

    // ~~~~~~~~~~~~~~~~~~~~
    // rx -> fifo -> tx
    // ~~~~~~~~~~~~~~~~~~~~

    uart_rx #(
        .CLK_PER_BIT (CLK_PER_BIT)
    ) rx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_line (rx_line),
        .rx_byte (rx_byte),
        .rx_push (rx_push)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_entry  (rx_byte),
        .wr_strobe (rx_push),
        .rd_entry  (fifo_out),
        .rd_valid  (fifo_valid),
        .rd_ready  (fifo_ready),
        .overrun   (overrun)
    );

    uart_tx #(
        .CLK_PER_BIT (CLK_PER_BIT)
    ) tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_entry (fifo_out),
        .tx_valid (fifo_valid),
        .tx_ready (fifo_ready),
        .hold     (tx_hold),
        .tx_line  (tx_line)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // low for 16 cycles, released between edges
    initial
    begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== sim/tb_uart_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_bridge;

    localparam int unsigned CLK_PER_BIT    = 16;
    localparam int unsigned FIFO_DEPTH     = 4;
    localparam int unsigned NUM_ROWS       = 14;
    localparam int unsigned TIMEOUT_CYCLES = (NUM_ROWS + 4) * 10 * CLK_PER_BIT * 2;

    // one serial frame of stimulus
    typedef struct packed {
        uart_pkg::byte_t data;
        logic            stop;
        logic            hold;
        logic            on_tx;
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            rx_line;
    logic            tx_hold;
    logic            tx_line;
    logic            overrun;
    row_t            stim [NUM_ROWS];
    uart_pkg::byte_t exp_q [$];
    int              mismatches = 0;
    int              extra_frames = 0;
    int              cycles = 0;

    tb_clock_gen clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    uart_bridge_top #(
        .CLK_PER_BIT (CLK_PER_BIT),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_line (rx_line),
        .tx_hold (tx_hold),
        .tx_line (tx_line),
        .overrun (overrun)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s, got %02h, expected %02h",
                     $time, what, actual, expected);
            mismatches++;
        end
    endtask

    // one bit time on rx_line; tx must stay quiet under hold
    task automatic drive_bit(input logic level);
        for (int c = 0; c < CLK_PER_BIT; c++)
        begin
            @(negedge clk);
            rx_line = level;
            if (tx_hold)
                check_value({7'd0, tx_line}, 8'h01, "tx_line left idle during hold");
        end
    endtask

    task automatic send_frame(input row_t r);
        logic [9:0] bits;
        bits = {r.stop, r.data, 1'b0};
        for (int i = 0; i < 10; i++)
            drive_bit(bits[i]);
        // a low stop bit needs a high gap before the next start edge
        if (!r.stop)
            drive_bit(1'b1);
    endtask

    // wait for every expected byte, then one more frame time
    // so a stray frame reaches the monitor
    task automatic drain_tx();
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (12 * CLK_PER_BIT) @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    initial
    begin : stimulus
        logic [31:0]     lfsr;
        uart_pkg::byte_t rnd;
        rx_line = 1'b1;
        tx_hold = 1'b0;
        lfsr    = 32'hb69aebc3;

        stim[0] = '{8'ha5, 1'b1, 1'b0, 1'b1};
        // burst rows, one lfsr step per bit
        for (int r = 1; r <= 4; r++)
        begin
            for (int b = 0; b < 8; b++)
            begin
                lfsr   = lfsr_next(lfsr);
                rnd[b] = lfsr[0];
            end
            stim[r] = '{rnd, 1'b1, 1'b0, 1'b1};
        end
        stim[5]  = '{8'h3c, 1'b1, 1'b0, 1'b1};
        stim[6]  = '{8'he7, 1'b0, 1'b0, 1'b0};
        stim[7]  = '{8'hc3, 1'b1, 1'b0, 1'b1};
        stim[8]  = '{8'h11, 1'b1, 1'b1, 1'b1};
        stim[9]  = '{8'h22, 1'b1, 1'b1, 1'b1};
        stim[10] = '{8'h33, 1'b1, 1'b1, 1'b1};
        stim[11] = '{8'h44, 1'b1, 1'b1, 1'b1};
        // fifo full, these two are dropped
        stim[12] = '{8'h55, 1'b1, 1'b1, 1'b0};
        stim[13] = '{8'h66, 1'b1, 1'b1, 1'b0};

        @(posedge rst_n);
        @(negedge clk);
        check_value({7'd0, tx_line}, 8'h01, "tx_line after reset");
        check_value({7'd0, overrun}, 8'h00, "overrun after reset");
        repeat (4 * CLK_PER_BIT)
        begin
            @(negedge clk);
            check_value({7'd0, tx_line}, 8'h01, "tx_line on a quiet input");
        end

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            if (stim[r].hold != tx_hold)
            begin
                drain_tx();
                @(negedge clk);
                tx_hold = stim[r].hold;
            end
            if (stim[r].on_tx)
                exp_q.push_back(stim[r].data);
            send_frame(stim[r]);
            // every kept byte found room in the fifo
            if (stim[r].on_tx)
                check_value({7'd0, overrun}, 8'h00, "overrun while the fifo has room");
        end
        check_value({7'd0, overrun}, 8'h01, "overrun after fifo overflow");

        @(negedge clk);
        tx_hold = 1'b0;
        drain_tx();
        check_value({7'd0, overrun}, 8'h01, "overrun after hold release");
        check_value({7'd0, tx_line}, 8'h01, "tx_line after drain");

        $display("errors: %0d mismatches, %0d unexpected bytes, %0d bytes missing",
                 mismatches, extra_frames, exp_q.size());
        if (mismatches == 0 && extra_frames == 0 && exp_q.size() == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // tx monitor
    // ~~~~~~~~~~~~~~~~~~~~

    initial
    begin : monitor
        uart_pkg::byte_t got;
        uart_pkg::byte_t want;
        @(posedge rst_n);
        forever
        begin
            @(negedge tx_line);
            // middle of the start bit
            repeat (CLK_PER_BIT / 2) @(negedge clk);
            check_value({7'd0, tx_line}, 8'h00, "start bit on tx_line");
            for (int i = 0; i < 8; i++)
            begin
                repeat (CLK_PER_BIT) @(negedge clk);
                got[i] = tx_line;
            end
            repeat (CLK_PER_BIT) @(negedge clk);
            check_value({7'd0, tx_line}, 8'h01, "stop bit on tx_line");
            if (exp_q.size() == 0)
            begin
                $display("unexpected byte %02h came out on tx_line at %0t ns", got, $time);
                extra_frames++;
            end
            else
            begin
                want = exp_q.pop_front();
                check_value(got, want, "byte on tx_line");
            end
        end
    end

    // run length guard
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("run timed out after %0d cycles", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

// ==== all.f ====
src/uart_pkg.sv
src/uart_rx.sv
src/byte_fifo.sv
src/uart_tx.sv
src/uart_bridge_top.sv
sim/tb_clock_gen.sv
sim/tb_uart_bridge.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_uart_bridge -o tb_uart_bridge
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_uart_bridge)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1
